//--- verilog/dphy_rx_pkg.sv
// D-PHY receive shared definitions
package dphy_rx_pkg;

  // Data lanes, one header word spans exactly one byte per lane
  localparam int LANES = 4;

  // HS sync pattern, sent LSB first
  localparam logic [7:0] SYNC_BYTE = 8'hB8;

  // Data types at or above this value carry a payload
  localparam logic [5:0] DT_LONG_MIN = 6'h10;

  // Parity masks over header bits 23:0, entry i gives ECC bit i
  localparam logic [5:0][23:0] ECC_MASK = '{
    24'hEFFC00,
    24'hDF03F0,
    24'hB8E38E,
    24'h749A6D,
    24'hF2555B,
    24'hF12CB7
  };

  // Header fields, lane 0 carries data_id
  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] wc;
    logic [7:0]  data_id;
  } csi2_hdr_fields_s;

  // Header word seen as raw bits or as fields
  typedef union packed {
    logic [31:0]      raw;
    csi2_hdr_fields_s f;
  } csi2_hdr_u;

endpackage

//--- verilog/dphy_byte_align.sv
// D-PHY lane byte aligner
`timescale 1ns/1ns

module dphy_byte_align (
  input  logic       byte_clk_i,
  input  logic       rst_i,
  input  logic       enable_i,
  input  logic       sync_reset_i,
  input  logic [7:0] lane_byte_i,
  output logic [7:0] aligned_byte_o,
  output logic       aligned_valid_o
);

  import dphy_rx_pkg::*;

  logic [7:0]  prev_byte;
  logic [15:0] window;
  logic        hit;
  logic [2:0]  hit_offset;
  logic        locked_q;
  logic [2:0]  offset_q;

  // Previous byte holds the earlier bits of the window
  always_ff @(posedge byte_clk_i)
  begin
    prev_byte <= lane_byte_i;
  end

  // Bit 0 arrived first, so the older byte sits in the low half
  assign window = {lane_byte_i, prev_byte};

  // Scan offsets from high to low so that the lowest match is kept
  always_comb
  begin
    hit        = 1'b0;
    hit_offset = 3'd0;
    for (int k = 7; k >= 0; k--)
    begin
      if (window[k +: 8] == SYNC_BYTE)
      begin
        hit        = 1'b1;
        hit_offset = 3'(k);
      end
    end
  end

  // Search and lock control
  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i || sync_reset_i || !enable_i)
    begin
      locked_q        <= 1'b0;
      offset_q        <= 3'd0;
      aligned_valid_o <= 1'b0;
    end
    else if (!locked_q)
    begin
      // Offset is frozen on the cycle the sync byte completes
      if (hit)
      begin
        locked_q <= 1'b1;
        offset_q <= hit_offset;
      end
    end
    else
    begin
      // Locked, every following byte is good
      aligned_valid_o <= 1'b1;
    end
  end

  // Aligned data, extracted at the locked offset
  always_ff @(posedge byte_clk_i)
  begin
    aligned_byte_o <= window[offset_q +: 8];
  end

endmodule

//--- verilog/dphy_word_align.sv
// D-PHY lane deskew and word assembly
`timescale 1ns/1ns

module dphy_word_align (
  input  logic                                 byte_clk_i,
  input  logic                                 rst_i,
  input  logic                                 enable_i,
  input  logic                                 pkt_done_i,
  input  logic [dphy_rx_pkg::LANES-1:0][7:0]   byte_data_i,
  input  logic [dphy_rx_pkg::LANES-1:0]        valid_i,
  output logic                                 sync_reset_o,
  output logic [dphy_rx_pkg::LANES-1:0][7:0]   word_o,
  output logic                                 valid_o
);

  import dphy_rx_pkg::*;

  logic [LANES-1:0][7:0] data_d1;
  logic [LANES-1:0][7:0] data_d2;
  logic [LANES-1:0][7:0] data_d3;
  logic [LANES-1:0]      valid_d1;
  logic [LANES-1:0]      valid_d2;
  logic [LANES-1:0]      valid_d3;
  logic [LANES-1:0][1:0] sel;
  logic [LANES-1:0][1:0] sel_q;
  logic                  all_valid;
  logic                  lane_long_valid;
  logic                  false_start;

  // Every lane has reached the first delay stage
  assign all_valid = &valid_d1;

  // Some lane has been valid for three cycles
  always_comb
  begin
    lane_long_valid = 1'b0;
    for (int i = 0; i < LANES; i++)
    begin
      if (valid_d1[i] && valid_d2[i] && valid_d3[i])
        lane_long_valid = 1'b1;
    end
  end

  // Skew larger than two cycles, or a lane that never synced
  assign false_start  = lane_long_valid && !all_valid;
  assign sync_reset_o = pkt_done_i || false_start;

  // Data delay line, three stages per lane
  always_ff @(posedge byte_clk_i)
  begin
    if (enable_i)
    begin
      data_d1 <= byte_data_i;
      data_d2 <= data_d1;
      data_d3 <= data_d2;
    end
  end

  // Valid delay line
  // Flushed on a resync so stale valids cannot restart a word
  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i || !enable_i || sync_reset_o)
    begin
      valid_d1 <= '0;
      valid_d2 <= '0;
      valid_d3 <= '0;
    end
    else
    begin
      valid_d1 <= valid_i;
      valid_d2 <= valid_d1;
      valid_d3 <= valid_d2;
    end
  end

  // Word valid runs from the first aligned word until packet end
  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i || pkt_done_i || !enable_i)
      valid_o <= 1'b0;
    else if (all_valid)
      valid_o <= 1'b1;
  end

  // Stage choice
  // Early lanes read from a deeper stage to wait for the late ones
  always_comb
  begin
    sel = sel_q;
    if (all_valid && !valid_o)
    begin
      for (int i = 0; i < LANES; i++)
      begin
        if (valid_d3[i])
          sel[i] = 2'd2;
        else if (valid_d2[i])
          sel[i] = 2'd1;
        else
          sel[i] = 2'd0;
      end
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i)
      sel_q <= '0;
    else
      sel_q <= sel;
  end

  // Deskewed word from the chosen stages
  always_ff @(posedge byte_clk_i)
  begin
    for (int i = 0; i < LANES; i++)
    begin
      case (sel[i])
        2'd2:    word_o[i] <= data_d3[i];
        2'd1:    word_o[i] <= data_d2[i];
        default: word_o[i] <= data_d1[i];
      endcase
    end
  end

endmodule

//--- verilog/csi2_hdr_ecc.sv
// CSI-2 packet header ECC check
`timescale 1ns/1ns

module csi2_hdr_ecc (
  input  dphy_rx_pkg::csi2_hdr_u hdr_i,
  output logic                   ecc_ok_o
);

  import dphy_rx_pkg::*;

  logic [23:0] hdr_bits;
  logic [7:0]  ecc_rx;
  logic [5:0]  parity;
  logic        top_clear;

  // Protected part of the header, data_id and word count
  assign hdr_bits = hdr_i.raw[23:0];

  // Received ECC byte
  assign ecc_rx = hdr_i.raw[31:24];

  // Each parity bit is the XOR of the masked header bits
  always_comb
  begin
    for (int i = 0; i < 6; i++)
    begin
      parity[i] = ^(hdr_bits & ECC_MASK[i]);
    end
  end

  // Two spare ECC bits are sent as zero
  assign top_clear = (ecc_rx[7:6] == 2'b00);

  // Detection only, any mismatch drops the header
  assign ecc_ok_o = top_clear && (ecc_rx[5:0] == parity);

endmodule

//--- verilog/csi2_pkt_ctrl.sv
// CSI-2 packet controller
`timescale 1ns/1ns

module csi2_pkt_ctrl (
  input  logic                   byte_clk_i,
  input  logic                   rst_i,
  input  logic [31:0]            word_i,
  input  logic                   word_valid_i,
  input  logic                   ecc_ok_i,
  output dphy_rx_pkg::csi2_hdr_u hdr_o,
  output logic                   pkt_done_o,
  output logic                   pkt_start_o,
  output logic [7:0]             data_id_o,
  output logic [15:0]            word_count_o,
  output logic [31:0]            payload_o,
  output logic [3:0]             payload_be_o,
  output logic                   payload_valid_o,
  output logic                   ecc_err_o
);

  import dphy_rx_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    HEADER_CHECK,
    PAYLOAD
  } state_e;

  state_e      state_q;
  state_e      state_d;
  logic        in_check;
  logic        is_long;
  logic        take_word;
  logic        last_word;
  logic        done_q;
  logic [15:0] rem_q;
  logic [15:0] bytes_left;
  logic [3:0]  be;

  // First word of a burst is the header
  always_ff @(posedge byte_clk_i)
  begin
    if (state_q == IDLE && word_valid_i)
      hdr_o.raw <= word_i;
  end

  assign data_id_o    = hdr_o.f.data_id;
  assign word_count_o = hdr_o.f.wc;

  assign in_check = (state_q == HEADER_CHECK);

  // Long packet with at least one payload byte
  assign is_long = (hdr_o.f.data_id[5:0] >= DT_LONG_MIN) && (hdr_o.f.wc != 16'd0);

  // Payload words start right behind a good long header
  assign take_word = word_valid_i &&
                     ((in_check && ecc_ok_i && is_long) ||
                      (state_q == PAYLOAD && rem_q != 16'd0));

  // On the first payload word the bytes owed are the whole word count
  assign bytes_left = in_check ? hdr_o.f.wc : rem_q;
  assign last_word  = (bytes_left <= 16'(LANES));

  // Byte enables cover only the bytes still owed
  always_comb
  begin
    case (bytes_left)
      16'd1:   be = 4'b0001;
      16'd2:   be = 4'b0011;
      16'd3:   be = 4'b0111;
      default: be = 4'b1111;
    endcase
  end

  // Header outcome shows in the cycle after the header
  assign pkt_start_o = in_check && ecc_ok_i;
  assign ecc_err_o   = in_check && !ecc_ok_i;

  // Short or bad header ends at once and a long one ends with its last word
  assign pkt_done_o = (in_check && !(ecc_ok_i && is_long)) || done_q;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (word_valid_i)
          state_d = HEADER_CHECK;
      HEADER_CHECK:
        state_d = pkt_done_o ? IDLE : PAYLOAD;
      PAYLOAD:
        // Burst lost mid packet also drops back
        if (done_q || !word_valid_i)
          state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  // Control state
  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i)
    begin
      state_q         <= IDLE;
      rem_q           <= 16'd0;
      done_q          <= 1'b0;
      payload_valid_o <= 1'b0;
    end
    else
    begin
      state_q         <= state_d;
      done_q          <= take_word && last_word;
      payload_valid_o <= take_word;
      if (take_word)
        rem_q <= last_word ? 16'd0 : bytes_left - 16'(LANES);
      else if (state_d == IDLE)
        rem_q <= 16'd0;
    end
  end

  // Payload data lags the word aligner by one cycle
  always_ff @(posedge byte_clk_i)
  begin
    if (take_word)
    begin
      payload_o    <= word_i;
      payload_be_o <= be;
    end
  end

endmodule

//--- verilog/dphy_rx_top.sv
// D-PHY four lane CSI-2 receiver
`timescale 1ns/1ns

module dphy_rx_top (
  input  logic                               byte_clk_i,
  input  logic                               rst_i,
  input  logic                               enable_i,
  input  logic [dphy_rx_pkg::LANES-1:0][7:0] lane_byte_i,
  output logic                               pkt_start_o,
  output logic [7:0]                         data_id_o,
  output logic [15:0]                        word_count_o,
  output logic [31:0]                        payload_o,
  output logic [3:0]                         payload_be_o,
  output logic                               payload_valid_o,
  output logic                               pkt_end_o,
  output logic                               ecc_err_o
);

  import dphy_rx_pkg::*;

  logic [LANES-1:0][7:0] aligned_byte;
  logic [LANES-1:0]      aligned_valid;
  logic                  sync_reset;
  logic [LANES-1:0][7:0] word;
  logic                  word_valid;
  logic                  pkt_done;
  logic                  ecc_ok;
  csi2_hdr_u             hdr;

  // One byte aligner per lane, all rearmed by the word aligner
  for (genvar i = 0; i < LANES; i++)
  begin : g_lane
    dphy_byte_align u_byte_align (
      .byte_clk_i      (byte_clk_i),
      .rst_i           (rst_i),
      .enable_i        (enable_i),
      .sync_reset_i    (sync_reset),
      .lane_byte_i     (lane_byte_i[i]),
      .aligned_byte_o  (aligned_byte[i]),
      .aligned_valid_o (aligned_valid[i])
    );
  end

  dphy_word_align u_word_align (
    .byte_clk_i   (byte_clk_i),
    .rst_i        (rst_i),
    .enable_i     (enable_i),
    .pkt_done_i   (pkt_done),
    .byte_data_i  (aligned_byte),
    .valid_i      (aligned_valid),
    .sync_reset_o (sync_reset),
    .word_o       (word),
    .valid_o      (word_valid)
  );

  csi2_hdr_ecc u_hdr_ecc (
    .hdr_i    (hdr),
    .ecc_ok_o (ecc_ok)
  );

  csi2_pkt_ctrl u_pkt_ctrl (
    .byte_clk_i      (byte_clk_i),
    .rst_i           (rst_i),
    .word_i          (word),
    .word_valid_i    (word_valid),
    .ecc_ok_i        (ecc_ok),
    .hdr_o           (hdr),
    .pkt_done_o      (pkt_done),
    .pkt_start_o     (pkt_start_o),
    .data_id_o       (data_id_o),
    .word_count_o    (word_count_o),
    .payload_o       (payload_o),
    .payload_be_o    (payload_be_o),
    .payload_valid_o (payload_valid_o),
    .ecc_err_o       (ecc_err_o)
  );

  // Packet end seen outside is the burst end
  assign pkt_end_o = pkt_done;

endmodule

//--- test/tb_dphy_rx.sv
// D-PHY receiver testbench
`timescale 1ns/1ns

module tb_dphy_rx;

  import dphy_rx_pkg::*;

  logic                  byte_clk;
  logic                  rst;
  logic                  enable;
  logic [LANES-1:0][7:0] lane_byte;
  logic                  pkt_start;
  logic [7:0]            data_id;
  logic [15:0]           word_count;
  logic [31:0]           payload;
  logic [3:0]            payload_be;
  logic                  payload_valid;
  logic                  pkt_end;
  logic                  ecc_err;

  logic [15:0] lfsr = 16'd44452;
  bit          lane_bits[LANES][$];
  logic [23:0] exp_hdr[$];
  logic [35:0] exp_words[$];
  int          exp_errs;
  int          exp_ends;
  int          errors;
  int          starts;
  int          ends;

  dphy_rx_top uut (
    .byte_clk_i      (byte_clk),
    .rst_i           (rst),
    .enable_i        (enable),
    .lane_byte_i     (lane_byte),
    .pkt_start_o     (pkt_start),
    .data_id_o       (data_id),
    .word_count_o    (word_count),
    .payload_o       (payload),
    .payload_be_o    (payload_be),
    .payload_valid_o (payload_valid),
    .pkt_end_o       (pkt_end),
    .ecc_err_o       (ecc_err)
  );

  initial
  begin
    byte_clk = 1'b0;
    forever #2 byte_clk = ~byte_clk;
  end

  // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    begin
      r = '0;
      for (int i = 0; i < n; i++)
      begin
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        r = {r[14:0], lfsr[0]};
      end
      return r;
    end
  endfunction

  // CSI-2 header parity where bit i comes from mask i
  function automatic logic [5:0] header_parity(input logic [23:0] bits);
    logic [23:0] masks[6] = '{24'hF12CB7, 24'hF2555B, 24'h749A6D,
                              24'hB8E38E, 24'hDF03F0, 24'hEFFC00};
    logic [5:0]  p;
    begin
      for (int i = 0; i < 6; i++)
        p[i] = ^(bits & masks[i]);
      return p;
    end
  endfunction

  // Build the lane bit streams for one packet and drive them
  task automatic send_packet(input logic [7:0] id, input logic [15:0] wc, input int flip,
                             input int dead_lane, input bit skewed);
    logic [7:0]  pkt[$];
    logic [31:0] hdr;
    logic [31:0] w;
    logic [3:0]  be;
    int          lead;
    int          len;
    begin
      hdr = {2'b00, header_parity({wc, id}), wc, id};
      if (flip >= 0)
        hdr[flip] = ~hdr[flip];
      // Header bytes first, lane 0 gets data_id
      for (int b = 0; b < 4; b++)
        pkt.push_back(hdr[8*b +: 8]);
      if (id[5:0] >= DT_LONG_MIN)
        for (int n = 0; n < int'(wc); n++)
          pkt.push_back(8'(rand_bits(8)));
      // Expected results only for a packet that should arrive
      if (flip >= 0)
        exp_errs++;
      if (dead_lane < 0)
        exp_ends++;
      if (flip < 0 && dead_lane < 0)
      begin
        exp_hdr.push_back({id, wc});
        for (int i = 4; i < pkt.size(); i += 4)
        begin
          w = '0;
          for (int b = 0; b < 4; b++)
            if (i + b < pkt.size())
              w[8*b +: 8] = pkt[i + b];
          // Remainder bytes set the low enables of the last word
          be = (i + 4 >= pkt.size() && int'(wc) % 4 != 0) ?
               4'((1 << (int'(wc) % 4)) - 1) : 4'hF;
          exp_words.push_back({be, w});
        end
      end
      len = 0;
      for (int l = 0; l < LANES; l++)
      begin
        lane_bits[l].delete();
        lead = skewed ? int'(rand_bits(3)) + 8 * (int'(rand_bits(2)) % 3) : 0;
        repeat (lead) lane_bits[l].push_back(1'b0);
        if (l != dead_lane)
        begin
          for (int b = 0; b < 8; b++)
            lane_bits[l].push_back(SYNC_BYTE[b]);
          for (int n = l; n < pkt.size(); n += LANES)
            for (int b = 0; b < 8; b++)
              lane_bits[l].push_back(pkt[n][b]);
        end
        // Trailer long enough to flush the receive pipeline
        repeat (96) lane_bits[l].push_back(1'b0);
        if (lane_bits[l].size() > len)
          len = lane_bits[l].size();
      end
      len = (len + 7) / 8 * 8;
      // One byte per lane per clock, LSB first
      for (int j = 0; j < len / 8; j++)
      begin
        @(posedge byte_clk);
        #1;
        for (int l = 0; l < LANES; l++)
          for (int b = 0; b < 8; b++)
            lane_byte[l][b] = (8*j + b < lane_bits[l].size()) ? lane_bits[l][8*j + b] : 1'b0;
      end
      lane_byte = '0;
    end
  endtask

  // Wait until the packet end count reaches the expected count
  task automatic wait_pkt_end(input int target);
    int t;
    begin
      t = 0;
      while (ends < target && t < 400)
      begin
        @(posedge byte_clk);
        t++;
      end
      if (ends < target)
      begin
        errors++;
        $display("Timed out at %0t waiting for a packet end", $time);
      end
    end
  endtask

  // Output checks against the expected queues
  always @(negedge byte_clk)
  begin
    if (!rst)
    begin
      if (pkt_start)
      begin
        starts++;
        assert (exp_hdr.size() > 0 && {data_id, word_count} == exp_hdr[0])
        else
        begin
          errors++;
          $display("FAIL %0t data_id/word_count got %h exp %h", $time,
                   {data_id, word_count}, exp_hdr.size() > 0 ? exp_hdr[0] : 24'hx);
        end
        if (exp_hdr.size() > 0)
          void'(exp_hdr.pop_front());
      end
      if (ecc_err)
      begin
        assert (exp_errs > 0)
        else
        begin
          errors++;
          $display("Unexpected ECC error at %0t", $time);
        end
        exp_errs--;
      end
      if (payload_valid)
      begin
        // Bytes outside the enables are padding
        assert (exp_words.size() > 0 && payload_be == exp_words[0][35:32] &&
                (payload & {{8{payload_be[3]}}, {8{payload_be[2]}}, {8{payload_be[1]}},
                 {8{payload_be[0]}}}) == exp_words[0][31:0])
        else
        begin
          errors++;
          $display("FAIL %0t payload_be/payload_o got %h exp %h", $time,
                   {payload_be, payload}, exp_words.size() > 0 ? exp_words[0] : 36'hx);
        end
        if (exp_words.size() > 0)
          void'(exp_words.pop_front());
      end
      if (pkt_end)
        ends++;
    end
  end

  initial
  begin
    rst = 1'b1;
    enable = 1'b0;
    lane_byte = '0;
    repeat (5) @(posedge byte_clk);
    #1;
    rst = 1'b0;
    enable = 1'b1;
    repeat (4) @(posedge byte_clk);

    // Short packet on aligned lanes
    send_packet(8'h00, 16'h0001, -1, -1, 1'b0);
    wait_pkt_end(exp_ends);
    // Long packets with random offset and skew and every remainder
    send_packet(8'h2A, 16'd32, -1, -1, 1'b1);
    wait_pkt_end(exp_ends);
    for (int wc = 5; wc <= 8; wc++)
    begin
      send_packet(8'h6B, 16'(wc + 8), -1, -1, 1'b1);
      wait_pkt_end(exp_ends);
    end
    // Corrupted header then a good one
    send_packet(8'h01, 16'h0007, 26, -1, 1'b1);
    wait_pkt_end(exp_ends);
    send_packet(8'h2B, 16'd10, -1, -1, 1'b1);
    wait_pkt_end(exp_ends);
    // Lane 2 never syncs and then recovers
    send_packet(8'h02, 16'h0003, -1, 2, 1'b1);
    send_packet(8'h2C, 16'd12, -1, -1, 1'b1);
    wait_pkt_end(exp_ends);
    // Back to back packets
    send_packet(8'h2A, 16'd6, -1, -1, 1'b1);
    send_packet(8'h03, 16'h0004, -1, -1, 1'b1);
    wait_pkt_end(exp_ends);
    repeat (20) @(posedge byte_clk);

    assert (exp_hdr.size() == 0 && exp_words.size() == 0 && exp_errs == 0 && ends == exp_ends)
    else
    begin
      errors++;
      $display("Missing output: %0d headers, %0d words, %0d ECC errors, %0d of %0d ends",
               exp_hdr.size(), exp_words.size(), exp_errs, ends, exp_ends);
    end
    $display("Errors %0d, packets started %0d, ended %0d", errors, starts, ends);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- compile.f
verilog/dphy_rx_pkg.sv
verilog/dphy_byte_align.sv
verilog/dphy_word_align.sv
verilog/csi2_hdr_ecc.sv
verilog/csi2_pkt_ctrl.sv
verilog/dphy_rx_top.sv
test/tb_dphy_rx.sv

//--- Makefile
TOP = tb_dphy_rx

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only -f compile.f --top-module dphy_rx_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
